// File: run_sim.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing \
  -f sim.f \
  --top-module dma_bridge_tb \
  -o dma_bridge_sim

./obj_dir/dma_bridge_sim

// File: sim.f
+incdir+source
source/dmab_pkg.sv
source/req_queue.sv
source/write_engine.sv
source/read_engine.sv
source/fromhost_arbiter.sv
source/dma_bridge.sv
tb/dma_bridge_chk.sv
tb/dma_bridge_tb.sv

// File: source/dma_bridge.sv
//**************************************************************************
// top of the bridge, one DMA port pair against an m_axis and an s_axis
// requests are two words, only the first word's fields are decoded
//**************************************************************************
`include "dmab_consts.svh"

module dma_bridge
  import dmab_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  dma_word_t  tohost_word,
  input  logic       tohost_valid,
  output logic       tohost_hold,
  output dma_word_t  fromhost_word,
  output logic       fromhost_valid,
  input  logic       fromhost_accept,
  output axis_beat_t m_axis_beat,
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  input  axis_beat_t s_axis_beat,
  input  logic       s_axis_tvalid,
  output logic       s_axis_tready
);

  dma_word_t wr_req_word;
  dma_word_t rd_req_word;
  logic      wr_req_valid;
  logic      rd_req_valid;
  logic      wr_req_end;
  logic      rd_req_end;
  logic      wr_accept;
  logic      rd_accept;
  logic      wr_stall;
  rd_req_t   rd_req_q;
  rd_req_t   q_head;
  logic      q_push;
  logic      q_pop;
  logic      q_nonempty;
  logic      q_full;
  logic      is_req;
  logic      is_wr_dir;
  logic      take;
  logic      wr_start;
  logic      req_odd_q;    // next request word is word 2
  logic      first_wr_q;   // direction of word 1

  //************************************************************************
  // request decode
  //************************************************************************
  assign is_req    = tohost_word.ctrl[`DMAB_CTRL_REQ] && !tohost_word.ctrl[`DMAB_CTRL_LAST];
  assign is_wr_dir = tohost_word.data[`DMAB_DIR_BIT];

  assign tohost_hold = wr_stall || (is_req && !req_odd_q && !is_wr_dir && q_full);
  assign take        = tohost_valid && !tohost_hold;

  assign wr_start = take && is_req && !req_odd_q && is_wr_dir;
  assign q_push   = take && is_req && req_odd_q && !first_wr_q;   // read, on word 2

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_odd_q  <= 1'b0;
      first_wr_q <= 1'b0;
    end
    else if (take && is_req)
    begin
      req_odd_q <= !req_odd_q;
      if (!req_odd_q)
        first_wr_q <= is_wr_dir;
    end
  end

  always_ff @(posedge clk)
  begin
    if (take && is_req && !req_odd_q)
    begin
      rd_req_q.tag <= tohost_word.data[`DMAB_TAG_HI:`DMAB_TAG_LO];
      rd_req_q.len <= tohost_word.data[`DMAB_LEN_HI:`DMAB_LEN_LO];
    end
  end

  //************************************************************************
  // instances
  //************************************************************************
  req_queue req_queue_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (q_push),
    .push_req (rd_req_q),
    .pop      (q_pop),
    .head     (q_head),
    .nonempty (q_nonempty),
    .full     (q_full)
  );

  write_engine write_engine_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .tohost_word   (tohost_word),
    .tohost_take   (take),
    .start         (wr_start),
    .m_axis_beat   (m_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .stall         (wr_stall),
    .req_word      (wr_req_word),
    .req_valid     (wr_req_valid),
    .req_end       (wr_req_end),
    .accept        (wr_accept)
  );

  read_engine read_engine_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .head          (q_head),
    .nonempty      (q_nonempty),
    .pop           (q_pop),
    .s_axis_beat   (s_axis_beat),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .req_word      (rd_req_word),
    .req_valid     (rd_req_valid),
    .req_end       (rd_req_end),
    .accept        (rd_accept)
  );

  fromhost_arbiter fromhost_arbiter_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wr_word         (wr_req_word),
    .wr_valid        (wr_req_valid),
    .wr_end          (wr_req_end),
    .wr_accept       (wr_accept),
    .rd_word         (rd_req_word),
    .rd_valid        (rd_req_valid),
    .rd_end          (rd_req_end),
    .rd_accept       (rd_accept),
    .fromhost_word   (fromhost_word),
    .fromhost_valid  (fromhost_valid),
    .fromhost_accept (fromhost_accept)
  );

endmodule

// File: source/dmab_consts.svh
//**************************************************************************
// widths, ctrl bit positions and request field positions of the DMA port
// data width is fixed at 64, tags are 4 bits, lengths count 32-bit dwords
//**************************************************************************
`ifndef DMAB_CONSTS_SVH
`define DMAB_CONSTS_SVH

`define DMAB_DATA_W      64
`define DMAB_CTRL_W      8
`define DMAB_KEEP_W      8
`define DMAB_TAG_W       4
`define DMAB_LEN_W       16

// ctrl bits
`define DMAB_CTRL_ACK1   0
`define DMAB_CTRL_DLO    2     // lower dword valid
`define DMAB_CTRL_LAST   3
`define DMAB_CTRL_REQ    4
`define DMAB_CTRL_ACK2   5

// ctrl code of the final read data word
`define DMAB_END_HALF    8'h14
`define DMAB_END_FULL    8'h1c

`define DMAB_KEEP_HALF   8'h0f
`define DMAB_KEEP_FULL   8'hff

// fields of request word 1
`define DMAB_TAG_HI      39
`define DMAB_TAG_LO      36
`define DMAB_DIR_BIT     63    // 1 = write
`define DMAB_LEN_HI      15
`define DMAB_LEN_LO      0

// tag position inside ack1 data
`define DMAB_ACK_TAG_HI  7
`define DMAB_ACK_TAG_LO  4

`define DMAB_QDEPTH      4

`endif

// File: source/dmab_pkg.sv
//**************************************************************************
// shared types of the DMA to AXI-stream bridge
// the same word struct serves both tohost and fromhost directions
//**************************************************************************
`include "dmab_consts.svh"

package dmab_pkg;

  typedef logic [`DMAB_DATA_W-1:0] data_t;
  typedef logic [`DMAB_CTRL_W-1:0] ctrl_t;
  typedef logic [`DMAB_KEEP_W-1:0] keep_t;
  typedef logic [`DMAB_TAG_W-1:0]  tag_t;
  typedef logic [`DMAB_LEN_W-1:0]  dw_len_t;   // length in 32-bit dwords

  // one word on the DMA port, 72 bits
  typedef struct packed {
    ctrl_t ctrl;
    data_t data;
  } dma_word_t;

  // one beat on either stream
  typedef struct packed {
    data_t tdata;
    keep_t tkeep;
    logic  tlast;
  } axis_beat_t;

  // decoded read request as kept in the queue
  typedef struct packed {
    tag_t    tag;
    dw_len_t len;
  } rd_req_t;

  //************************************************************************
  // engine states
  //************************************************************************
  typedef enum logic [2:0] {
    WR_IDLE,
    WR_REQ2,   // skip host info word
    WR_DATA,
    WR_ACK1,
    WR_ACK2
  } wr_state_t;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ACK1,
    RD_ACK2,
    RD_DATA
  } rd_state_t;

endpackage

// File: source/fromhost_arbiter.sv
//**************************************************************************
// packet arbiter for the fromhost bus, round robin between the two engines
// the grant locks as soon as a word is shown and frees on the accepted end
//**************************************************************************
module fromhost_arbiter
  import dmab_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  dma_word_t wr_word,
  input  logic      wr_valid,
  input  logic      wr_end,
  output logic      wr_accept,
  input  dma_word_t rd_word,
  input  logic      rd_valid,
  input  logic      rd_end,
  output logic      rd_accept,
  output dma_word_t fromhost_word,
  output logic      fromhost_valid,
  input  logic      fromhost_accept
);

  localparam logic OWN_WR = 1'b0;
  localparam logic OWN_RD = 1'b1;

  logic busy_q;
  logic owner_q;
  logic last_q;   // owner of the previous packet
  logic sel;
  logic cur_end;

  always_comb
  begin
    if (busy_q)
      sel = owner_q;
    else if (wr_valid && rd_valid)
      sel = ~last_q;   // both waiting, take turns
    else
      sel = rd_valid ? OWN_RD : OWN_WR;
  end

  assign fromhost_word  = (sel == OWN_RD) ? rd_word  : wr_word;
  assign fromhost_valid = (sel == OWN_RD) ? rd_valid : wr_valid;
  assign cur_end        = (sel == OWN_RD) ? rd_end   : wr_end;

  assign wr_accept = fromhost_accept && (sel == OWN_WR);
  assign rd_accept = fromhost_accept && (sel == OWN_RD);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q  <= 1'b0;
      owner_q <= OWN_WR;
      last_q  <= OWN_RD;   // write wins the first tie
    end
    else if (fromhost_valid && fromhost_accept && cur_end)
    begin
      busy_q <= 1'b0;
      last_q <= sel;
    end
    else if (fromhost_valid)
    begin
      busy_q  <= 1'b1;   // keeps an unaccepted word stable
      owner_q <= sel;
    end
  end

endmodule

// File: source/read_engine.sv
//**************************************************************************
// read path, one queued request gives ack1, ack2, then the s_axis beats
// the response length follows tlast on s_axis, not the requested length
//**************************************************************************
`include "dmab_consts.svh"

module read_engine
  import dmab_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  rd_req_t    head,
  input  logic       nonempty,
  output logic       pop,
  input  axis_beat_t s_axis_beat,
  input  logic       s_axis_tvalid,
  output logic       s_axis_tready,
  output dma_word_t  req_word,
  output logic       req_valid,
  output logic       req_end,
  input  logic       accept
);

  rd_state_t state;
  rd_state_t state_nxt;
  rd_req_t   cur_q;
  ctrl_t     end_code;

  assign pop = (state == RD_IDLE) && nonempty;

  // final word code from the fill of the last beat
  assign end_code = (s_axis_beat.tkeep <= `DMAB_KEEP_HALF) ? `DMAB_END_HALF
                                                           : `DMAB_END_FULL;

  // a beat moves only when its fromhost word is accepted
  assign s_axis_tready = (state == RD_DATA) && accept;

  //************************************************************************
  // state machine
  //************************************************************************
  always_comb
  begin
    state_nxt = state;
    case (state)
      RD_IDLE: if (nonempty) state_nxt = RD_ACK1;
      RD_ACK1: if (accept) state_nxt = RD_ACK2;
      RD_ACK2: if (accept) state_nxt = RD_DATA;
      RD_DATA:
      begin
        if (s_axis_tvalid && accept && s_axis_beat.tlast)
          state_nxt = RD_IDLE;
      end
      default: state_nxt = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= RD_IDLE;
    else
      state <= state_nxt;
  end

  always_ff @(posedge clk)
  begin
    if (pop)
      cur_q <= head;   // copy of the popped entry
  end

  //************************************************************************
  // words toward the arbiter
  //************************************************************************
  always_comb
  begin
    req_word  = '0;
    req_valid = 1'b0;
    req_end   = 1'b0;
    case (state)
      RD_ACK1:
      begin
        req_word.ctrl[`DMAB_CTRL_ACK1] = 1'b1;
        req_word.data[`DMAB_ACK_TAG_HI:`DMAB_ACK_TAG_LO] = cur_q.tag;
        req_valid = 1'b1;
      end
      RD_ACK2:
      begin
        req_word.ctrl[`DMAB_CTRL_ACK2] = 1'b1;
        req_word.data[`DMAB_LEN_HI:`DMAB_LEN_LO] = cur_q.len;
        req_valid = 1'b1;
      end
      RD_DATA:
      begin
        req_word.data = s_axis_beat.tdata;
        if (s_axis_beat.tlast)
          req_word.ctrl = end_code;
        else
          req_word.ctrl[`DMAB_CTRL_DLO] = 1'b1;
        req_valid = s_axis_tvalid;
        req_end   = s_axis_beat.tlast;
      end
      default:
      begin
        req_valid = 1'b0;
      end
    endcase
  end

endmodule

// File: source/req_queue.sv
//**************************************************************************
// circular buffer of pending read requests, head is valid while nonempty
// pushing while full is not allowed, the top holds the host off instead
//**************************************************************************
`include "dmab_consts.svh"

module req_queue
  import dmab_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    push,
  input  rd_req_t push_req,
  input  logic    pop,
  output rd_req_t head,
  output logic    nonempty,
  output logic    full
);

  localparam int PTR_W = $clog2(`DMAB_QDEPTH);
  localparam int CNT_W = $clog2(`DMAB_QDEPTH + 1);

  rd_req_t            mem [`DMAB_QDEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;

  assign head     = mem[rd_ptr];
  assign nonempty = (count != '0);
  assign full     = (count == CNT_W'(`DMAB_QDEPTH));

  // storage, no reset
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_req;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
      if (pop && nonempty)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop && nonempty})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: source/write_engine.sv
//**************************************************************************
// write path, tohost data goes straight to m_axis, then an ack pair goes out
// a new write request is held off until the previous ack pair has left
//**************************************************************************
`include "dmab_consts.svh"

module write_engine
  import dmab_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  dma_word_t  tohost_word,
  input  logic       tohost_take,
  input  logic       start,
  output axis_beat_t m_axis_beat,
  output logic       m_axis_tvalid,
  input  logic       m_axis_tready,
  output logic       stall,
  output dma_word_t  req_word,
  output logic       req_valid,
  output logic       req_end,
  input  logic       accept
);

  wr_state_t state;
  wr_state_t state_nxt;
  tag_t      tag_q;
  dw_len_t   len_q;
  logic      last_word;
  logic      new_wr_req;
  logic      in_ack;

  assign last_word  = tohost_word.ctrl[`DMAB_CTRL_LAST];
  assign new_wr_req = tohost_word.ctrl[`DMAB_CTRL_REQ] && !last_word &&
                      tohost_word.data[`DMAB_DIR_BIT];
  assign in_ack     = (state == WR_ACK1) || (state == WR_ACK2);

  //************************************************************************
  // data pass-through, zero latency
  //************************************************************************
  always_comb
  begin
    m_axis_beat.tdata = tohost_word.data;
    m_axis_beat.tlast = last_word;
    // odd dword count leaves the upper half of the last word empty
    m_axis_beat.tkeep = (last_word && len_q[0]) ? `DMAB_KEEP_HALF : `DMAB_KEEP_FULL;
  end

  assign m_axis_tvalid = (state == WR_DATA) && tohost_take;

  // hold the host while the stream is stalled or an earlier ack is pending
  assign stall = ((state == WR_DATA) && !m_axis_tready) || (in_ack && new_wr_req);

  //************************************************************************
  // state machine
  //************************************************************************
  always_comb
  begin
    state_nxt = state;
    case (state)
      WR_IDLE: if (start) state_nxt = WR_REQ2;
      WR_REQ2: if (tohost_take) state_nxt = WR_DATA;
      WR_DATA: if (tohost_take && last_word) state_nxt = WR_ACK1;
      WR_ACK1: if (accept) state_nxt = WR_ACK2;
      WR_ACK2: if (accept) state_nxt = WR_IDLE;
      default: state_nxt = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= WR_IDLE;
    else
      state <= state_nxt;
  end

  // request fields, taken from word 1 only
  always_ff @(posedge clk)
  begin
    if (state == WR_IDLE && start)
    begin
      tag_q <= tohost_word.data[`DMAB_TAG_HI:`DMAB_TAG_LO];
      len_q <= tohost_word.data[`DMAB_LEN_HI:`DMAB_LEN_LO];
    end
  end

  //************************************************************************
  // ack words toward the arbiter
  //************************************************************************
  always_comb
  begin
    req_word  = '0;
    req_valid = 1'b0;
    req_end   = 1'b0;
    case (state)
      WR_ACK1:
      begin
        req_word.ctrl[`DMAB_CTRL_ACK1] = 1'b1;
        req_word.ctrl[`DMAB_CTRL_REQ]  = 1'b1;   // upstream ack
        req_word.data[`DMAB_ACK_TAG_HI:`DMAB_ACK_TAG_LO] = tag_q;
        req_valid = 1'b1;
      end
      WR_ACK2:
      begin
        req_word.ctrl[`DMAB_CTRL_ACK2] = 1'b1;
        req_word.ctrl[`DMAB_CTRL_REQ]  = 1'b1;
        req_word.data[`DMAB_LEN_HI:`DMAB_LEN_LO] = len_q;
        req_valid = 1'b1;
        req_end   = 1'b1;   // ends the packet
      end
      default:
      begin
        req_valid = 1'b0;
      end
    endcase
  end

endmodule

// File: tb/dma_bridge_chk.sv
//**************************************************************************
// protocol checker bound to the bridge top that sees the top-level ports only
//**************************************************************************
module dma_bridge_chk
  import dmab_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       tohost_hold,
  input dma_word_t  fromhost_word,
  input logic       fromhost_valid,
  input logic       fromhost_accept,
  input logic       m_axis_tvalid,
  input logic       s_axis_tvalid,
  input logic       s_axis_tready
);

  // outputs quiet in reset and on the first edge after it
  reset_quiet: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |->
      !fromhost_valid && !m_axis_tvalid && !s_axis_tready && !tohost_hold)
    else $error("outputs active during or right after reset");

  // unaccepted word stays put
  fromhost_stable: assert property (@(posedge clk) disable iff (!rst_n)
    fromhost_valid && !fromhost_accept |=> fromhost_valid && $stable(fromhost_word))
    else $error("fromhost word changed before it was accepted");

  // s_axis only moves together with an accepted fromhost word
  s_axis_coupled: assert property (@(posedge clk) disable iff (!rst_n)
    s_axis_tready |-> fromhost_accept && (fromhost_valid || !s_axis_tvalid))
    else $error("s_axis ready without an accepted fromhost word");

endmodule

bind dma_bridge dma_bridge_chk dma_bridge_chk_i (.*);

// File: tb/dma_bridge_tb.sv
//**************************************************************************
// random host and stream models around the bridge
// expected words wait in queues until the bridge produces them
// a timeout bounds the run
//**************************************************************************
module dma_bridge_tb
  import dmab_pkg::*;
();

  localparam int NUM_REQ = 20;
  localparam int TIMEOUT = NUM_REQ * 40;   // cycles after reset

  logic       clk;
  logic       rst_n;
  dma_word_t  tohost_word;
  logic       tohost_valid;
  logic       tohost_hold;
  dma_word_t  fromhost_word;
  logic       fromhost_valid;
  logic       fromhost_accept;
  axis_beat_t m_axis_beat;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  axis_beat_t s_axis_beat;
  logic       s_axis_tvalid;
  logic       s_axis_tready;

  axis_beat_t m_exp[$];    // expected m_axis beats
  axis_beat_t s_src[$];    // beats the s_axis source still has to send
  dma_word_t  wr_exp[$];   // expected write ack words
  dma_word_t  rd_exp[$];   // expected read response words
  logic       rd_last[$];  // end of packet flag per read word
  int         cycles;
  int         pkt_owner;   // 0 idle, 1 write packet, 2 read packet

  dma_bridge dma_bridge_i (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //**************************************************************************
  // failure reporting
  //**************************************************************************
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [72:0] got,
                             input logic [72:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  //**************************************************************************
  // host model
  //**************************************************************************
  task automatic send_word(input dma_word_t w);
    tohost_word  = w;
    tohost_valid = 1'b1;
    @(negedge clk);
    while (tohost_hold)   // host keeps the word
      @(negedge clk);
    @(posedge clk);
    #5;
    tohost_valid = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #5;
    end
  endtask

  task automatic do_write();
    tag_t       tag;
    dw_len_t    len;
    int         beats;
    dma_word_t  w;
    axis_beat_t b;
    tag   = tag_t'($urandom % 16);
    len   = dw_len_t'(1 + $urandom % 9);
    beats = (len + 1) / 2;
    wr_exp.push_back({8'h11, 56'h0, tag, 4'h0});   // ack1 with REQ
    wr_exp.push_back({8'h30, 48'h0, len});         // ack2 with REQ
    w.ctrl = 8'h10;
    w.data = {1'b1, 23'h0, tag, 20'h0, len};
    send_word(w);
    w.data = {$urandom, $urandom};   // host info word
    send_word(w);
    for (int i = 0; i < beats; i++)
    begin
      b.tdata = {$urandom, $urandom};
      b.tlast = (i == beats - 1);
      b.tkeep = (b.tlast && len[0]) ? 8'h0f : 8'hff;
      m_exp.push_back(b);
      w.ctrl = b.tlast ? 8'h0c : 8'h04;
      w.data = b.tdata;
      send_word(w);
    end
  endtask

  task automatic do_read();
    tag_t       tag;
    dw_len_t    len;
    int         beats;
    dma_word_t  w;
    axis_beat_t b;
    tag   = tag_t'($urandom % 16);
    len   = dw_len_t'(1 + $urandom % 9);
    beats = (len + 1) / 2;
    rd_exp.push_back({8'h01, 56'h0, tag, 4'h0});
    rd_exp.push_back({8'h20, 48'h0, len});
    rd_last.push_back(1'b0);
    rd_last.push_back(1'b0);
    for (int i = 0; i < beats; i++)
    begin
      b.tdata = {$urandom, $urandom};
      b.tlast = (i == beats - 1);
      b.tkeep = (b.tlast && len[0]) ? 8'h0f : 8'hff;
      s_src.push_back(b);
      if (b.tlast)
        rd_exp.push_back({(b.tkeep <= 8'h0f) ? 8'h14 : 8'h1c, b.tdata});
      else
        rd_exp.push_back({8'h04, b.tdata});
      rd_last.push_back(b.tlast);
    end
    w.ctrl = 8'h10;
    w.data = {1'b0, 23'h0, tag, 20'h0, len};
    send_word(w);
    w.data = {$urandom, $urandom};
    send_word(w);
  endtask

  //**************************************************************************
  // stream side and fromhost back-pressure
  //**************************************************************************
  always @(posedge clk)
  begin
    #5;
    fromhost_accept = ($urandom % 4) != 0;
    m_axis_tready   = ($urandom % 4) != 0;
    s_axis_tvalid   = (s_src.size() > 0);
    if (s_src.size() > 0)
      s_axis_beat = s_src[0];   // held until taken
  end

  // monitor sampled in the middle of the cycle
  always @(negedge clk)
  begin
    dma_word_t exp_w;
    logic      end_w;
    if (rst_n)
    begin
      cycles++;
      if (cycles > TIMEOUT)
        fail_run("timeout: the transfers did not finish within the cycle limit");
      if (m_axis_tvalid && m_axis_tready)
      begin
        if (m_exp.size() == 0)
          fail_run("m_axis carried a beat that no write request asked for");
        check_value("m_axis_beat", m_axis_beat, m_exp.pop_front());
      end
      if (s_axis_tvalid && s_axis_tready)
        void'(s_src.pop_front());
      if (fromhost_valid && fromhost_accept)
      begin
        if (pkt_owner == 0)
          pkt_owner = fromhost_word.ctrl[4] ? 1 : 2;   // REQ marks write acks
        if (pkt_owner == 1)
        begin
          if (wr_exp.size() == 0)
            fail_run("fromhost carried a write ack that no write request asked for");
          exp_w = wr_exp.pop_front();
          end_w = (exp_w.ctrl == 8'h30);
        end
        else
        begin
          if (rd_exp.size() == 0)
            fail_run("fromhost carried a read word that no read request asked for");
          exp_w = rd_exp.pop_front();
          end_w = rd_last.pop_front();
        end
        check_value("fromhost_word", fromhost_word, exp_w);
        if (end_w)
          pkt_owner = 0;
      end
    end
  end

  //**************************************************************************
  // main sequence
  //**************************************************************************
  initial
  begin
    void'($urandom(32'heb5a_4ed2));
    rst_n           = 1'b0;
    tohost_word     = '0;
    tohost_valid    = 1'b0;
    fromhost_accept = 1'b0;
    m_axis_tready   = 1'b0;
    s_axis_beat     = '0;
    s_axis_tvalid   = 1'b0;
    cycles          = 0;
    pkt_owner       = 0;
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;
    repeat (6) do_read();   // back to back reads fill the queue
    for (int i = 6; i < NUM_REQ; i++)
    begin
      if ($urandom % 2)
        do_write();
      else
        do_read();
      idle($urandom % 3);
    end
    while (m_exp.size() > 0 || wr_exp.size() > 0 || rd_exp.size() > 0 || s_src.size() > 0)
      @(posedge clk);
    repeat (4) @(negedge clk);
    if (!fromhost_valid)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
      fail_run("the bridge still offers a fromhost word after all transfers finished");
  end

endmodule
